// File: Bender.yml
package:
  name: energy_core

sources:
  - lagd_pkg.sv
  - weight_if.sv
  - energy_ctrl.sv
  - row_counter.sv
  - weight_fetch.sv
  - energy_accum.sv
  - best_tracker.sv
  - energy_core.sv
  - target: test
    files:
      - tb_energy_core.sv

// File: best_tracker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// best_tracker
// Lowest energy and its spin vector since flush.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module best_tracker
    import lagd_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    flush_i,
    input  logic    update_i,
    input  energy_t energy_i,
    input  spin_t   spin_i,
    output logic    best_valid_o,
    output energy_t best_energy_o,
    output spin_t   best_spin_o
);

    logic    valid_q;
    energy_t energy_q;
    spin_t   spin_q;
    logic    take;

    // ties keep the older state
    assign take = update_i && !flush_i && (!valid_q || (energy_i < energy_q));

    assign best_valid_o  = valid_q;
    assign best_energy_o = energy_q;
    assign best_spin_o   = spin_q;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (take) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            energy_q <= energy_i;
            spin_q   <= spin_i;
        end
    end

endmodule

// File: energy_accum.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// energy_accum
// Turns weight words, spins and biases into the
// running Ising energy of one job.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module energy_accum
    import lagd_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   clear_i,
    input  spin_t                  spin_i,
    input  hbias_t                 hbias_i,
    input  logic [SCALING_BIT-1:0] hscaling_i,
    weight_if.dst                  in,
    output logic                   last_done_o,
    output energy_t                energy_o
);

    // sum_j J_ij*s_j + hscaling*h_i for one row
    function automatic logic signed [ROW_W-1:0] row_value(
        input logic [ROW_BITS-1:0]    row,
        input spin_t                  spins,
        input logic signed [BITH-1:0] h,
        input logic [SCALING_BIT-1:0] scale
    );
        logic signed [ROW_W-1:0] acc;
        logic signed [BITJ-1:0]  j_val;
        acc = signed'({1'b0, scale}) * h;
        for (int j = 0; j < NUM_SPIN; j++) begin
            j_val = row[j*BITJ +: BITJ];
            if (spins[j]) acc = acc + j_val;
            else          acc = acc - j_val;
        end
        return acc;
    endfunction

    logic                    in_hs;
    addr_t                   word_idx_q;
    logic [SPIN_IDX_W-1:0]   row_base;
    logic signed [ROW_W-1:0] row_val [PARALLELISM];
    energy_t                 word_sum;
    energy_t                 energy_q;
    logic                    last_done_q;

    // never stalls
    assign in.ready    = 1'b1;
    assign in_hs       = in.valid & in.ready;
    assign row_base    = SPIN_IDX_W'(word_idx_q * PARALLELISM);
    assign energy_o    = energy_q;
    assign last_done_o = last_done_q;

    always_comb begin
        word_sum = '0;
        for (int p = 0; p < PARALLELISM; p++) begin
            row_val[p] = row_value(in.data[p*ROW_BITS +: ROW_BITS], spin_i,
                                   hbias_i[(row_base + p)*BITH +: BITH], hscaling_i);
            // s_i = +1 adds the row, s_i = -1 subtracts it
            if (spin_i[row_base + p]) word_sum = word_sum + row_val[p];
            else                      word_sum = word_sum - row_val[p];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            word_idx_q  <= '0;
            last_done_q <= 1'b0;
        end else begin
            last_done_q <= in_hs & in.last;
            if (clear_i) begin
                word_idx_q <= '0;
            end else if (in_hs) begin
                word_idx_q <= word_idx_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (clear_i) begin
            energy_q <= '0;
        end else if (in_hs) begin
            energy_q <= energy_q + word_sum;
        end
    end

endmodule

// File: energy_core.f
lagd_pkg.sv
weight_if.sv
energy_ctrl.sv
row_counter.sv
weight_fetch.sv
energy_accum.sv
best_tracker.sv
energy_core.sv
tb_energy_core.sv

// File: energy_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// energy_core
// Ising energy core: spin in, weights streamed from
// memory, energy out, best state tracked.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module energy_core
    import lagd_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   flush_i,
    input  logic                   spin_valid_i,
    output logic                   spin_ready_o,
    input  spin_t                  spin_i,
    output logic                   energy_valid_o,
    input  logic                   energy_ready_i,
    output energy_t                energy_o,
    output spin_t                  spin_o,
    output logic                   weight_ren_o,
    output addr_t                  weight_raddr_o,
    input  weight_word_t           weight_rdata_i,
    input  hbias_t                 hbias_i,
    input  logic [SCALING_BIT-1:0] hscaling_i,
    output logic                   best_valid_o,
    output energy_t                best_energy_o,
    output spin_t                  best_spin_o
);

    logic  job_start;
    logic  accum_clear;
    logic  last_done;
    logic  step;
    addr_t addr;
    logic  addr_last;
    logic  out_hs;

    weight_if u_wif ();

    assign out_hs = energy_valid_o & energy_ready_i;

    energy_ctrl u_ctrl (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .spin_valid_i   (spin_valid_i),
        .spin_ready_o   (spin_ready_o),
        .spin_i         (spin_i),
        .energy_ready_i (energy_ready_i),
        .last_done_i    (last_done),
        .job_start_o    (job_start),
        .accum_clear_o  (accum_clear),
        .energy_valid_o (energy_valid_o),
        .spin_o         (spin_o)
    );

    row_counter u_counter (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .start_i (job_start),
        .step_i  (step),
        .addr_o  (addr),
        .last_o  (addr_last)
    );

    weight_fetch u_fetch (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (job_start),
        .addr_i      (addr),
        .addr_last_i (addr_last),
        .step_o      (step),
        .mem_ren_o   (weight_ren_o),
        .mem_raddr_o (weight_raddr_o),
        .mem_rdata_i (weight_rdata_i),
        .out         (u_wif.src)
    );

    energy_accum u_accum (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .clear_i     (accum_clear),
        .spin_i      (spin_o),
        .hbias_i     (hbias_i),
        .hscaling_i  (hscaling_i),
        .in          (u_wif.dst),
        .last_done_o (last_done),
        .energy_o    (energy_o)
    );

    // best state follows the output handshake
    best_tracker u_best (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (flush_i),
        .update_i      (out_hs),
        .energy_i      (energy_o),
        .spin_i        (spin_o),
        .best_valid_o  (best_valid_o),
        .best_energy_o (best_energy_o),
        .best_spin_o   (best_spin_o)
    );

endmodule

// File: energy_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// energy_ctrl
// Job sequencer: accepts a spin vector, starts the
// weight stream and hands the energy off.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module energy_ctrl
    import lagd_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  spin_valid_i,
    output logic  spin_ready_o,
    input  spin_t spin_i,
    input  logic  energy_ready_i,
    input  logic  last_done_i,
    output logic  job_start_o,
    output logic  accum_clear_o,
    output logic  energy_valid_o,
    output spin_t spin_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_HOLD
    } state_e;

    state_e state_q;
    logic   spin_hs;
    logic   start_q;
    spin_t  spin_q;

    assign spin_ready_o   = (state_q == ST_IDLE);
    assign spin_hs        = spin_valid_i & spin_ready_o;
    assign energy_valid_o = (state_q == ST_HOLD);
    assign job_start_o    = start_q;
    // accumulator is cleared together with the start pulse
    assign accum_clear_o  = start_q;
    assign spin_o         = spin_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            start_q <= 1'b0;
        end else begin
            start_q <= spin_hs;
            case (state_q)
                ST_IDLE: if (spin_hs) state_q <= ST_RUN;
                ST_RUN:  if (last_done_i) state_q <= ST_HOLD;
                ST_HOLD: if (energy_ready_i) state_q <= ST_IDLE;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // spin vector travels with the job
    always_ff @(posedge clk_i) begin
        if (spin_hs) begin
            spin_q <= spin_i;
        end
    end

    a_done_in_run: assert property (@(posedge clk_i) disable iff (rst_i)
        last_done_i |-> state_q == ST_RUN)
        else $error("last word reported outside a running job");

endmodule

// File: lagd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// lagd_pkg
// Sizes, derived widths and shared types of the
// Ising energy core.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package lagd_pkg;

    // problem size
    localparam int NUM_SPIN    = 16;
    localparam int BITJ        = 4;
    localparam int BITH        = BITJ;
    localparam int SCALING_BIT = 4;
    localparam int PARALLELISM = 2;

    // weight stream
    localparam int NUM_WORDS   = NUM_SPIN / PARALLELISM;
    localparam int ADDR_W      = $clog2(NUM_WORDS);
    localparam int FETCH_DEPTH = 2;
    localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);
    localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);

    // datapath widths
    localparam int ENERGY_W    = 24;
    localparam int SPIN_IDX_W  = $clog2(NUM_SPIN);
    localparam int ROW_BITS    = NUM_SPIN * BITJ;
    // one row plus its bias term, with headroom for sign
    localparam int ROW_W       = BITJ + SPIN_IDX_W + 2;

    typedef logic [NUM_SPIN-1:0]              spin_t;
    typedef logic [ROW_BITS*PARALLELISM-1:0]  weight_word_t;
    typedef logic [NUM_SPIN*BITH-1:0]         hbias_t;
    typedef logic signed [ENERGY_W-1:0]       energy_t;
    typedef logic [ADDR_W-1:0]                addr_t;

endpackage

// File: row_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// row_counter
// Steps through the weight addresses of one job.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module row_counter
    import lagd_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  start_i,
    input  logic  step_i,
    output addr_t addr_o,
    output logic  last_o
);

    addr_t addr_q;
    // read at the final address already issued
    logic  last_issued_q;

    assign addr_o = addr_q;
    assign last_o = (addr_q == addr_t'(NUM_WORDS - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            addr_q        <= '0;
            last_issued_q <= 1'b0;
        end else if (start_i) begin
            addr_q        <= '0;
            last_issued_q <= 1'b0;
        end else if (step_i) begin
            if (last_o) begin
                last_issued_q <= 1'b1;
            end else begin
                addr_q <= addr_q + 1'b1;
            end
        end
    end

    a_no_extra_step: assert property (@(posedge clk_i) disable iff (rst_i)
        !(step_i && last_o && last_issued_q))
        else $error("weight read issued past the final address");

endmodule

// File: tb_energy_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_energy_core
// Self-checking testbench for the Ising energy core
// with weight memory model and energy reference.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_energy_core
    import lagd_pkg::*;
();

    localparam int     NUM_JOBS   = 200;
    localparam int     TOTAL_JOBS = NUM_JOBS + 2;
    localparam int     CLK_PERIOD = 4;
    localparam longint TIMEOUT    = TOTAL_JOBS * (NUM_WORDS + 20) * CLK_PERIOD * 4;

    logic                   clk_i = 1'b0;
    logic                   rst_i;
    logic                   flush_i;
    logic                   spin_valid_i;
    logic                   spin_ready_o;
    spin_t                  spin_i;
    logic                   energy_valid_o;
    logic                   energy_ready_i;
    energy_t                energy_o;
    spin_t                  spin_o;
    logic                   weight_ren_o;
    addr_t                  weight_raddr_o;
    weight_word_t           weight_rdata_i;
    hbias_t                 hbias_i;
    logic [SCALING_BIT-1:0] hscaling_i;
    logic                   best_valid_o;
    energy_t                best_energy_o;
    spin_t                  best_spin_o;

    int           seed;
    weight_word_t words [NUM_WORDS];
    int           read_cnt;
    logic         pend_valid = 1'b0;
    addr_t        pend_addr;
    // running minimum of the reference
    bit           best_held;
    energy_t      best_e;
    spin_t        best_s;

    energy_core u_dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .flush_i        (flush_i),
        .spin_valid_i   (spin_valid_i),
        .spin_ready_o   (spin_ready_o),
        .spin_i         (spin_i),
        .energy_valid_o (energy_valid_o),
        .energy_ready_i (energy_ready_i),
        .energy_o       (energy_o),
        .spin_o         (spin_o),
        .weight_ren_o   (weight_ren_o),
        .weight_raddr_o (weight_raddr_o),
        .weight_rdata_i (weight_rdata_i),
        .hbias_i        (hbias_i),
        .hscaling_i     (hscaling_i),
        .best_valid_o   (best_valid_o),
        .best_energy_o  (best_energy_o),
        .best_spin_o    (best_spin_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string test, input longint expected, input longint actual);
        assert (expected == actual)
        else report_failure($sformatf("Mismatch in %s: expected %0d, actual %0d",
                                      test, expected, actual));
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond)
        else report_failure(msg);
    endtask

    // memory model with one cycle read latency and address order check
    always @(negedge clk_i) begin
        weight_rdata_i = pend_valid ? words[pend_addr] : '0;
        pend_valid     = weight_ren_o;
        pend_addr      = weight_raddr_o;
        if (weight_ren_o) begin
            check_value("address_order", read_cnt, weight_raddr_o);
            check_true(read_cnt < NUM_WORDS, "more weight reads than words in one job");
            read_cnt++;
        end
    end

    // s = +1 for bit 1, -1 for bit 0; row i adds s_i*(sum_j J_ij*s_j + hs*h_i)
    task automatic energy_model(input spin_t s, output energy_t e);
        int                     total;
        int                     row_sum;
        int                     row;
        logic signed [BITJ-1:0] j_val;
        logic signed [BITH-1:0] h_val;
        total = 0;
        for (int w = 0; w < NUM_WORDS; w++) begin
            for (int p = 0; p < PARALLELISM; p++) begin
                row     = w * PARALLELISM + p;
                h_val   = hbias_i[row*BITH +: BITH];
                row_sum = int'(hscaling_i) * int'(h_val);
                for (int j = 0; j < NUM_SPIN; j++) begin
                    j_val   = words[w][p*ROW_BITS + j*BITJ +: BITJ];
                    row_sum = s[j] ? row_sum + int'(j_val) : row_sum - int'(j_val);
                end
                total = s[row] ? total + row_sum : total - row_sum;
            end
        end
        e = energy_t'(total);
    endtask

    task automatic randomize_job();
        for (int w = 0; w < NUM_WORDS; w++) begin
            for (int k = 0; k < $bits(weight_word_t) / 32; k++) begin
                words[w][k*32 +: 32] = $random(seed);
            end
        end
        hbias_i    = {$random(seed), $random(seed)};
        hscaling_i = SCALING_BIT'($random(seed));
    endtask

    task automatic flush_best();
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i   = 1'b0;
        best_held = 1'b0;
        check_true(!best_valid_o, "best_valid_o still high one cycle after flush");
    endtask

    // one job from spin handshake to output handshake
    // starts and ends on a falling edge
    task automatic run_job(input string test, input spin_t s, input bit flush_on_hs);
        energy_t expected;
        energy_t held_energy;
        spin_t   held_spin;
        bit      held;
        bit      done;
        energy_model(s, expected);
        while (!spin_ready_o) @(negedge clk_i);
        read_cnt     = 0;
        spin_valid_i = 1'b1;
        spin_i       = s;
        @(negedge clk_i);
        spin_valid_i = 1'b0;
        spin_i       = spin_t'($random(seed));
        held         = 1'b0;
        done         = 1'b0;
        while (!done) begin
            if (energy_valid_o) begin
                if (held) begin
                    check_value("backpressure_hold", held_energy, energy_o);
                    check_value("backpressure_hold", held_spin, spin_o);
                end
                check_value(test, expected, energy_o);
                check_value(test, s, spin_o);
                check_true(!spin_ready_o, "spin_ready_o high while the energy output waits");
                held           = 1'b1;
                held_energy    = energy_o;
                held_spin      = spin_o;
                energy_ready_i = (($random(seed) & 3) != 0);
                done           = energy_ready_i;
                flush_i        = energy_ready_i & flush_on_hs;
            end else begin
                check_true(!held, "energy_valid_o dropped before the output handshake");
            end
            @(negedge clk_i);
        end
        energy_ready_i = 1'b0;
        flush_i        = 1'b0;
        check_value("address_order", NUM_WORDS, read_cnt);
        if (flush_on_hs) begin
            // flush wins over the update in the same cycle
            best_held = 1'b0;
            check_true(!best_valid_o, "best_valid_o still high one cycle after flush");
        end else begin
            if (!best_held || expected < best_e) begin
                best_held = 1'b1;
                best_e    = expected;
                best_s    = s;
            end
            check_true(best_valid_o, "best_valid_o low after an output handshake");
            check_value("best_state", best_e, best_energy_o);
            check_value("best_state", best_s, best_spin_o);
        end
    endtask

    initial begin
        seed           = 32'hfdf0_6eff;
        rst_i          = 1'b1;
        flush_i        = 1'b0;
        spin_valid_i   = 1'b0;
        spin_i         = '0;
        energy_ready_i = 1'b0;
        weight_rdata_i = '0;
        hbias_i        = '0;
        hscaling_i     = '0;
        read_cnt       = 0;
        best_held      = 1'b0;
        repeat (3) @(negedge clk_i);
        rst_i = 1'b0;
        check_true(spin_ready_o && !energy_valid_o && !weight_ren_o && !best_valid_o,
                   "outputs not in their idle state after reset");

        for (int n = 0; n < NUM_JOBS; n++) begin
            if (n == 100) begin
                flush_best();
            end
            randomize_job();
            run_job("energy_compute", spin_t'($random(seed)), n == 150);
        end

        // most negative couplings, largest bias and scaling
        for (int k = 0; k < 2; k++) begin
            for (int w = 0; w < NUM_WORDS; w++) begin
                words[w] = {(NUM_SPIN * PARALLELISM){1'b1, {(BITJ - 1){1'b0}}}};
            end
            hbias_i    = {NUM_SPIN{1'b0, {(BITH - 1){1'b1}}}};
            hscaling_i = '1;
            run_job("extreme_values", (k == 0) ? '1 : '0, 1'b0);
        end

        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(TIMEOUT);
        report_failure("watchdog expired before all jobs completed");
    end

endmodule

// File: weight_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// weight_fetch
// Issues weight reads against a credit count and
// queues returned words for the valid/ready stream.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module weight_fetch
    import lagd_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         start_i,
    input  addr_t        addr_i,
    input  logic         addr_last_i,
    output logic         step_o,
    output logic         mem_ren_o,
    output addr_t        mem_raddr_o,
    input  weight_word_t mem_rdata_i,
    weight_if.src        out
);

    logic                   active_q;
    logic                   rd_valid_q;
    logic                   rd_last_q;
    logic [FETCH_CNT_W-1:0] count_q;
    logic [FETCH_PTR_W-1:0] wr_ptr_q;
    logic [FETCH_PTR_W-1:0] rd_ptr_q;
    weight_word_t           data_mem_q [FETCH_DEPTH];
    logic                   last_mem_q [FETCH_DEPTH];
    logic                   empty;
    logic                   push;
    logic                   pop;

    // reads in flight plus buffered words bound the credit
    assign mem_ren_o   = active_q &
                         (({1'b0, count_q} + rd_valid_q) < FETCH_DEPTH);
    assign mem_raddr_o = addr_i;
    assign step_o      = mem_ren_o;

    assign empty     = (count_q == '0);
    assign out.valid = !empty || rd_valid_q;
    assign out.data  = empty ? mem_rdata_i : data_mem_q[rd_ptr_q];
    assign out.last  = empty ? rd_last_q : last_mem_q[rd_ptr_q];

    // returning word bypasses the buffer when it is empty and taken
    assign push = rd_valid_q && !(empty && out.ready);
    assign pop  = !empty && out.ready;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            active_q   <= 1'b0;
            rd_valid_q <= 1'b0;
            rd_last_q  <= 1'b0;
            count_q    <= '0;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
        end else begin
            if (start_i) begin
                active_q <= 1'b1;
            end else if (mem_ren_o && addr_last_i) begin
                active_q <= 1'b0;
            end
            rd_valid_q <= mem_ren_o;
            rd_last_q  <= mem_ren_o & addr_last_i;
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            count_q <= count_q + FETCH_CNT_W'(push) - FETCH_CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem_q[wr_ptr_q] <= mem_rdata_i;
            last_mem_q[wr_ptr_q] <= rd_last_q;
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i)
        !(rd_valid_q && count_q == FETCH_CNT_W'(FETCH_DEPTH)))
        else $error("weight word returned into a full buffer");

endmodule

// File: weight_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// weight_if
// Valid/ready stream of weight words from the fetch
// buffer to the energy accumulator.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

interface weight_if
    import lagd_pkg::*;
();

    logic         valid;
    logic         ready;
    weight_word_t data;
    // word fetched from the final address
    logic         last;

    modport src (output valid, output data, output last, input ready);
    modport dst (input valid, input data, input last, output ready);

endinterface
